// ==== Makefile ====
# Verilator build and run for the image scaling VGA path

VERILATOR  ?= verilator
TOP        ?= tb_img_scale_vga
RTL_TOP    ?= img_scale_vga
FILELIST   ?= img_scale_vga.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only -Wall
SIM_ARGS   ?= +verilator+error+limit+1000
RTL_FILES  := $(filter rtl/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== img_scale_vga.f ====
rtl/img_scale_pkg.sv
rtl/fb_port_if.sv
rtl/frame_buffer.sv
rtl/scale_engine.sv
rtl/vga_driver.sv
rtl/img_scale_vga.sv
testbench/img_scale_vga_asserts.sv
testbench/tb_img_scale_vga.sv

// ==== rtl/fb_port_if.sv ====
/* Frame buffer port bundle: one write port fed by the scale engine and one
   read port used by the VGA scanout, with a modport for each side. */

`timescale 1ns/100ps
`default_nettype none

interface fb_port_if;
    import img_scale_pkg::*;

    // write side, taken on any edge with wr_en high
    logic     wr_en;
    fb_addr_t wr_addr;
    pixel_t   wr_data;

    // read side, data one edge after address
    fb_addr_t rd_addr;
    pixel_t   rd_data;

    modport writer (
        output wr_en, wr_addr, wr_data
    );

    modport reader (
        output rd_addr,
        input  rd_data
    );

    modport mem (
        input  wr_en, wr_addr, wr_data, rd_addr,
        output rd_data
    );

endinterface

`default_nettype wire

// ==== rtl/frame_buffer.sv ====
/* 640x480 byte frame buffer, simple dual port. Synchronous write and a
   registered read, so rd_data follows rd_addr by one clock. */

`timescale 1ns/100ps
`default_nettype none

module frame_buffer (
    input  logic        clock,
    fb_port_if.mem      fb
);
    import img_scale_pkg::*;

    // one byte per screen pixel, 307200 entries
    pixel_t mem [fb_w * fb_h];

    // write port
    always_ff @(posedge clock) begin
        if (fb.wr_en) begin
            mem[fb.wr_addr] <= fb.wr_data;
        end
    end

    // read port, registered output
    // same-address read during write returns the old byte
    always_ff @(posedge clock) begin
        fb.rd_data <= mem[fb.rd_addr];
    end

endmodule

`default_nettype wire

// ==== rtl/img_scale_pkg.sv ====
/* Shared geometry, VGA timing and type definitions for the image scaling path.
   Compiled before every other RTL file; modules pull it in by wildcard import. */

`default_nettype none

package img_scale_pkg;

    // ==============================
    // pixel format
    // ==============================
    typedef logic [7:0] pixel_t;        // RGB332, red in [7:5], green [4:2], blue [1:0]

    // ==============================
    // source image, 160x120
    // ==============================
    localparam int src_w = 160;
    localparam int src_h = 120;

    // row * 160 + col
    typedef logic [$clog2(src_w * src_h)-1:0] src_addr_t;

    // ==============================
    // frame buffer, 640x480
    // ==============================
    localparam int fb_w = 640;
    localparam int fb_h = 480;

    // row * 640 + col
    typedef logic [$clog2(fb_w * fb_h)-1:0] fb_addr_t;

    typedef logic [9:0] coord_t;        // wide enough for 799 and 524

    // ==============================
    // VGA timing, 640x480 at pixel clock
    // ==============================
    localparam int h_front = 16;
    localparam int h_sync  = 96;
    localparam int h_back  = 48;
    localparam int h_total = fb_w + h_front + h_sync + h_back;    // 800

    localparam int v_front = 10;
    localparam int v_sync  = 2;
    localparam int v_back  = 33;
    localparam int v_total = fb_h + v_front + v_sync + v_back;    // 525

    // scale engine modes
    typedef enum logic [1:0] {
        mode_copy    = 2'd0,    // 1:1 into top-left corner
        mode_zoom2   = 2'd1,    // x2 nearest neighbour, top-left
        mode_zoom4   = 2'd2,    // x4 full screen
        mode_mirror4 = 2'd3     // x4, flipped left to right
    } scale_mode_t;

endpackage

`default_nettype wire

// ==== rtl/img_scale_vga.sv ====
/* Top level of the image path: scale engine fills the frame buffer from the
   external source memory, VGA driver scans it out. Single pixel clock. */

`timescale 1ns/100ps
`default_nettype none

module img_scale_vga (
    input  logic                       clock,      // pixel clock
    input  logic                       arst_n,
    // engine control
    input  logic                       start,
    input  img_scale_pkg::scale_mode_t mode,
    output logic                       busy,
    output logic                       done,
    // external source memory, 1 cycle read latency
    output img_scale_pkg::src_addr_t   rom_addr,
    input  img_scale_pkg::pixel_t      rom_data,
    // VGA
    output logic                       vga_hs,
    output logic                       vga_vs,
    output logic [7:0]                 vga_r,
    output logic [7:0]                 vga_g,
    output logic [7:0]                 vga_b,
    output logic                       vga_blank_n
);

    // ==============================
    // frame buffer ports
    // ==============================
    fb_port_if fb_if ();

    scale_engine u_scale_engine (
        .clock    (clock),
        .arst_n   (arst_n),
        .start    (start),
        .mode     (mode),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .busy     (busy),
        .done     (done),
        .fb       (fb_if.writer)
    );

    frame_buffer u_frame_buffer (
        .clock (clock),
        .fb    (fb_if.mem)
    );

    // scanout, outputs two cycles behind the counters
    vga_driver u_vga_driver (
        .clock       (clock),
        .arst_n      (arst_n),
        .fb          (fb_if.reader),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_blank_n (vga_blank_n)
    );

endmodule

`default_nettype wire

// ==== rtl/scale_engine.sv ====
/* Pixel engine: on start, walks the destination region set by mode, reads the
   matching source byte and writes it to the frame buffer two cycles later. */

`timescale 1ns/100ps
`default_nettype none

module scale_engine (
    input  logic                       clock,
    input  logic                       arst_n,
    input  logic                       start,
    input  img_scale_pkg::scale_mode_t mode,
    output img_scale_pkg::src_addr_t   rom_addr,
    input  img_scale_pkg::pixel_t      rom_data,
    output logic                       busy,
    output logic                       done,
    fb_port_if.writer                  fb
);
    import img_scale_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_run,     // one source read per cycle
        st_drain    // flush the two pixels in flight
    } state_t;

    state_t      state;
    scale_mode_t mode_q;      // latched at start
    coord_t      dst_col;
    coord_t      dst_row;
    coord_t      last_col;
    coord_t      last_row;
    coord_t      src_col;
    coord_t      src_row;
    fb_addr_t    dst_addr;
    fb_addr_t    addr_s1;     // dest address, waiting on rom_data
    logic        vld_s1;

    // ==============================
    // region and source mapping
    // ==============================
    always_comb begin
        case (mode_q)
            mode_copy: begin
                last_col = coord_t'(src_w - 1);
                last_row = coord_t'(src_h - 1);
                src_col  = dst_col;             // identity
                src_row  = dst_row;
            end
            mode_zoom2: begin
                last_col = coord_t'(2 * src_w - 1);
                last_row = coord_t'(2 * src_h - 1);
                src_col  = dst_col >> 1;        // halve
                src_row  = dst_row >> 1;
            end
            mode_zoom4: begin
                last_col = coord_t'(fb_w - 1);
                last_row = coord_t'(fb_h - 1);
                src_col  = dst_col >> 2;        // quarter
                src_row  = dst_row >> 2;
            end
            default: begin                      // mirror x4
                last_col = coord_t'(fb_w - 1);
                last_row = coord_t'(fb_h - 1);
                src_col  = coord_t'(src_w - 1) - (dst_col >> 2);
                src_row  = dst_row >> 2;
            end
        endcase
    end

    // x160 = x128 + x32
    assign rom_addr = (src_addr_t'(src_row) << 7) + (src_addr_t'(src_row) << 5)
                    + src_addr_t'(src_col);
    // x640 = x512 + x128
    assign dst_addr = (fb_addr_t'(dst_row) << 9) + (fb_addr_t'(dst_row) << 7)
                    + fb_addr_t'(dst_col);

    // ==============================
    // control FSM
    // ==============================
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state   <= st_idle;
            mode_q  <= mode_copy;
            dst_col <= '0;
            dst_row <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;                       // pulse only
            case (state)
                st_idle: if (start) begin       // start ignored elsewhere
                    state   <= st_run;
                    mode_q  <= mode;
                    dst_col <= '0;
                    dst_row <= '0;
                end
                st_run: begin
                    if (dst_col == last_col) begin
                        dst_col <= '0;
                        if (dst_row == last_row) begin
                            dst_row <= '0;      // last read issued
                            state   <= st_drain;
                        end else begin
                            dst_row <= dst_row + 1'b1;
                        end
                    end else begin
                        dst_col <= dst_col + 1'b1;
                    end
                end
                st_drain: if (!vld_s1) begin    // final write goes out this cycle
                    state <= st_idle;
                    done  <= 1'b1;
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign busy = (state != st_idle);

    // ==============================
    // write pipeline
    // ==============================
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            vld_s1   <= 1'b0;
            fb.wr_en <= 1'b0;
        end else begin
            vld_s1   <= (state == st_run);      // read issued this cycle
            fb.wr_en <= vld_s1;
        end
    end

    always_ff @(posedge clock) begin
        addr_s1    <= dst_addr;
        fb.wr_addr <= addr_s1;
        fb.wr_data <= rom_data;                 // rom answers one cycle after addr
    end

endmodule

`default_nettype wire

// ==== rtl/vga_driver.sv ====
/* 640x480 VGA scanout. Counters address the frame buffer during active video,
   sync and blank are delayed to meet the returning byte, all outputs registered. */

`timescale 1ns/100ps
`default_nettype none

module vga_driver (
    input  logic        clock,
    input  logic        arst_n,
    fb_port_if.reader   fb,
    output logic        vga_hs,
    output logic        vga_vs,
    output logic [7:0]  vga_r,
    output logic [7:0]  vga_g,
    output logic [7:0]  vga_b,
    output logic        vga_blank_n
);
    import img_scale_pkg::*;

    coord_t h_cnt;      // column, 0..799
    coord_t v_cnt;      // line, 0..524
    logic   active;
    logic   hs_c;       // low active
    logic   vs_c;
    logic   act_s1;     // aligned with rd_data
    logic   hs_s1;
    logic   vs_s1;
    pixel_t px;

    // ==============================
    // timing counters
    // ==============================
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == coord_t'(h_total - 1)) begin
            h_cnt <= '0;
            if (v_cnt == coord_t'(v_total - 1)) begin
                v_cnt <= '0;                    // frame wrap
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign active = (h_cnt < coord_t'(fb_w)) && (v_cnt < coord_t'(fb_h));

    // sync low for columns 656..751, lines 490..491
    assign hs_c = !((h_cnt >= coord_t'(fb_w + h_front)) &&
                    (h_cnt <  coord_t'(fb_w + h_front + h_sync)));
    assign vs_c = !((v_cnt >= coord_t'(fb_h + v_front)) &&
                    (v_cnt <  coord_t'(fb_h + v_front + v_sync)));

    // line * 640 + column, zero outside active area
    assign fb.rd_addr = active ? (fb_addr_t'(v_cnt) << 9) + (fb_addr_t'(v_cnt) << 7)
                                 + fb_addr_t'(h_cnt)
                               : '0;

    // ==============================
    // alignment and output stage
    // ==============================
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            act_s1 <= 1'b0;
            hs_s1  <= 1'b1;
            vs_s1  <= 1'b1;
        end else begin
            act_s1 <= active;                   // covers the memory read cycle
            hs_s1  <= hs_c;
            vs_s1  <= vs_c;
        end
    end

    assign px = fb.rd_data;

    // RGB332 to 8 bits per channel by bit replication
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            vga_hs      <= 1'b1;
            vga_vs      <= 1'b1;
            vga_blank_n <= 1'b0;
            vga_r       <= '0;
            vga_g       <= '0;
            vga_b       <= '0;
        end else begin
            vga_hs      <= hs_s1;
            vga_vs      <= vs_s1;
            vga_blank_n <= act_s1;
            if (act_s1) begin
                vga_r <= {px[7:5], px[7:5], px[7:6]};
                vga_g <= {px[4:2], px[4:2], px[4:3]};
                vga_b <= {4{px[1:0]}};
            end else begin
                vga_r <= '0;                    // black in blanking
                vga_g <= '0;
                vga_b <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/img_scale_vga_asserts.sv ====
/* Concurrent checks on the scale engine control and address rules.
   Attached to every scale_engine instance by the bind at the bottom. */

`timescale 1ns/100ps
`default_nettype none

module img_scale_vga_asserts (
    input logic                     clock,
    input logic                     arst_n,
    input logic                     busy,
    input logic                     done,
    input logic                     wr_en,
    input img_scale_pkg::src_addr_t rom_addr
);
    import img_scale_pkg::*;

    int fail_cnt = 0;   // read by the testbench at the end

    // done is a single pulse, raised as busy drops
    a_done_fall: assert property (@(posedge clock) disable iff (!arst_n)
        done |-> !busy && $past(busy))
        else begin $error("done without busy falling"); fail_cnt++; end
    a_done_once: assert property (@(posedge clock) disable iff (!arst_n)
        done |=> !done)
        else begin $error("done longer than one cycle"); fail_cnt++; end

    // source reads stay inside the 160x120 image
    a_rom_range: assert property (@(posedge clock) disable iff (!arst_n)
        busy |-> (rom_addr < src_addr_t'(src_w * src_h)))
        else begin $error("rom_addr out of range"); fail_cnt++; end

    a_wr_busy: assert property (@(posedge clock) disable iff (!arst_n)
        wr_en |-> busy)   // no stray writes when idle
        else begin $error("frame buffer write while idle"); fail_cnt++; end

endmodule

bind scale_engine img_scale_vga_asserts asserts_i (
    .clock    (clock),
    .arst_n   (arst_n),
    .busy     (busy),
    .done     (done),
    .wr_en    (fb.wr_en),
    .rom_addr (rom_addr)
);

`default_nettype wire

// ==== testbench/tb_img_scale_vga.sv ====
/* Testbench for img_scale_vga: source memory model, one table row per scale
   mode, and a full-frame scanout check against a model frame after each done. */

`timescale 1ns/100ps
`default_nettype none

module tb_img_scale_vga;
    import img_scale_pkg::*;

    typedef struct packed {
        scale_mode_t mode;
        logic        restart;   // extra start while busy
        coord_t      reg_w;     // written region
        coord_t      reg_h;
    } row_t;

    localparam int   n_rows = 4;
    localparam row_t rows [n_rows] = '{
        '{mode_zoom4,   1'b1, 10'd640, 10'd480},
        '{mode_copy,    1'b0, 10'd160, 10'd120},
        '{mode_zoom2,   1'b1, 10'd320, 10'd240},
        '{mode_mirror4, 1'b1, 10'd640, 10'd480}
    };
    // longest run plus two full frames per row, doubled
    localparam longint wd_cycles = 2 * n_rows * (307203 + 2 * 420000) + 16;

    logic        clock;
    logic        arst_n;
    logic        start;
    scale_mode_t mode;
    src_addr_t   rom_addr;
    src_addr_t   rom_addr_q = '0;
    pixel_t      rom_data = '0;
    logic        busy;
    logic        done;
    logic        vga_hs;
    logic        vga_vs;
    logic [7:0]  vga_r;
    logic [7:0]  vga_g;
    logic [7:0]  vga_b;
    logic        vga_blank_n;
    pixel_t      model [fb_w * fb_h];   // expected frame buffer

    img_scale_vga dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // source byte rule
    function automatic pixel_t rom_byte(input int unsigned a);
        return pixel_t'((a * 7) + (a >> 8));
    endfunction

    // one cycle read latency, driven on the falling edge
    always @(negedge clock) begin
        rom_addr_q <= rom_addr;
        rom_data   <= rom_byte(int'(rom_addr_q));
    end

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("ERR %s exp=%h got=%h", name, exp, got);
            abort_run();
        end
    endtask

    // RGB332 expansion by bit replication
    task automatic check_pixel(input int idx, input pixel_t exp,
                               input logic [7:0] r, input logic [7:0] g,
                               input logic [7:0] b);
        logic [2:0]  rr;
        logic [2:0]  gg;
        logic [1:0]  bb;
        logic [23:0] want;
        rr   = exp[7:5];
        gg   = exp[4:2];
        bb   = exp[1:0];
        want = {rr, rr, rr[2:1], gg, gg, gg[2:1], bb, bb, bb, bb};
        if ({r, g, b} !== want) begin
            $display("ERR vga_rgb pixel %0d exp=%h got=%h", idx, want, {r, g, b});
            abort_run();
        end
    endtask

    function automatic void paint_model(input row_t row);
        int f;
        int sc;
        int sr;
        f = int'(row.reg_w) / src_w;            // 1, 2 or 4
        for (int r = 0; r < int'(row.reg_h); r++) begin
            for (int c = 0; c < int'(row.reg_w); c++) begin
                sc = c / f;
                sr = r / f;
                if (row.mode == mode_mirror4) sc = src_w - 1 - sc;
                model[r * fb_w + c] = rom_byte(sr * src_w + sc);
            end
        end
    endfunction

    // wait for vs fall, then walk one whole frame in output coordinates
    task automatic scan_frame();
        logic prev_vs;
        logic act;
        int   h;
        int   v;
        prev_vs = vga_vs;
        @(negedge clock);
        while (!(prev_vs && !vga_vs)) begin
            check_bit("busy", 1'b0, busy);      // engine stays idle between rows
            check_bit("done", 1'b0, done);
            prev_vs = vga_vs;
            @(negedge clock);
        end
        h = 0;
        v = fb_h + v_front;                     // first sync line
        repeat (h_total * v_total) begin
            act = (h < fb_w) && (v < fb_h);
            check_bit("vga_hs", !(h >= 656 && h <= 751), vga_hs);  // sync columns 656..751
            check_bit("vga_vs", !(v >= 490 && v <= 491), vga_vs);  // sync lines 490..491
            check_bit("vga_blank_n", act, vga_blank_n);
            check_bit("busy", 1'b0, busy);
            check_pixel(v * fb_w + h, act ? model[v * fb_w + h] : pixel_t'(0),
                        vga_r, vga_g, vga_b);
            h++;
            if (h == h_total) begin
                h = 0;
                v = (v == v_total - 1) ? 0 : v + 1;
            end
            @(negedge clock);
        end
    endtask

    task automatic apply_row(input row_t row);
        int unsigned restart_at;
        int unsigned cyc;
        restart_at = ($urandom % 1000) + 4;
        cyc        = 0;
        start      = 1'b1;
        mode       = row.mode;
        @(negedge clock);
        start = 1'b0;
        mode  = scale_mode_t'(2'(row.mode) + 2'd1);   // must not reach the run
        check_bit("busy", 1'b1, busy);
        while (!done) begin
            check_bit("busy", 1'b1, busy);
            start = row.restart && (cyc == restart_at);
            @(negedge clock);
            cyc++;
        end
        start = 1'b0;
        check_bit("busy", 1'b0, busy);          // falls together with done
        paint_model(row);
        scan_frame();
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        void'($urandom(65));
        arst_n   = 1'b0;
        start    = 1'b0;
        mode     = mode_copy;
        repeat (16) @(negedge clock);
        check_bit("busy", 1'b0, busy);
        check_bit("done", 1'b0, done);
        check_bit("vga_blank_n", 1'b0, vga_blank_n);
        check_bit("vga_hs", 1'b1, vga_hs);
        check_bit("vga_vs", 1'b1, vga_vs);
        arst_n = 1'b1;
        repeat (4) @(negedge clock);
        for (int i = 0; i < n_rows; i++) begin
            apply_row(rows[i]);
        end
        if (dut_i.u_scale_engine.asserts_i.fail_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (wd_cycles) @(posedge clock);
        $display("timeout: run did not finish within %0d clock cycles", wd_cycles);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire
